//--- Makefile
TOP := tb_ialu

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- sim.f
+incdir+verilog
+incdir+sim
verilog/ialu_pkg.sv
verilog/ialu_decode.sv
verilog/ialu_result_unit.sv
verilog/ialu_serial_mul.sv
verilog/ialu_top.sv
sim/tb_ialu.sv

//--- sim/ialu_model.svh
// Reference model of the integer ALU, included inside the testbench module
// Results follow the RISC-V meaning of each command with 64-bit products

`ifndef IALU_MODEL_SVH
`define IALU_MODEL_SVH

// Outcome of a compare command or 0 for all others
function automatic logic model_flag(ialu_cmd_e c, logic [`IALU_XLEN-1:0] a,
                                    logic [`IALU_XLEN-1:0] b);
    case (c)
        IALU_CMD_LT  : return $signed(a) < $signed(b);
        IALU_CMD_LTU : return a < b;
        IALU_CMD_EQ  : return a == b;
        IALU_CMD_NE  : return a != b;
        IALU_CMD_GE  : return $signed(a) >= $signed(b);
        IALU_CMD_GEU : return a >= b;
        default      : return 1'b0;
    endcase
endfunction

function automatic logic [`IALU_XLEN-1:0] model_result(ialu_cmd_e c,
                                                     logic [`IALU_XLEN-1:0] a,
                                                     logic [`IALU_XLEN-1:0] b);
    logic signed [2*`IALU_XLEN-1:0] sa;
    logic signed [2*`IALU_XLEN-1:0] prod_ss;
    logic signed [2*`IALU_XLEN-1:0] prod_su;
    logic        [2*`IALU_XLEN-1:0] prod_uu;
    sa      = {{`IALU_XLEN{a[`IALU_XLEN-1]}}, a};
    prod_ss = sa * $signed({{`IALU_XLEN{b[`IALU_XLEN-1]}}, b});
    prod_su = sa * $signed({{`IALU_XLEN{1'b0}}, b});       // op2 taken as unsigned
    prod_uu = {{`IALU_XLEN{1'b0}}, a} * {{`IALU_XLEN{1'b0}}, b};
    case (c)
        IALU_CMD_AND    : return a & b;
        IALU_CMD_OR     : return a | b;
        IALU_CMD_XOR    : return a ^ b;
        IALU_CMD_ADD    : return a + b;
        IALU_CMD_SUB    : return a - b;
        IALU_CMD_SLL    : return a << b[`IALU_SHAMT_W-1:0];
        IALU_CMD_SRL    : return a >> b[`IALU_SHAMT_W-1:0];
        IALU_CMD_SRA    : return $signed(a) >>> b[`IALU_SHAMT_W-1:0];
        IALU_CMD_MUL    : return prod_ss[`IALU_XLEN-1:0];
        IALU_CMD_MULH   : return prod_ss[2*`IALU_XLEN-1:`IALU_XLEN];
        IALU_CMD_MULHSU : return prod_su[2*`IALU_XLEN-1:`IALU_XLEN];
        IALU_CMD_MULHU  : return prod_uu[2*`IALU_XLEN-1:`IALU_XLEN];
        default         : return `IALU_XLEN'(model_flag(c, a, b));  // Compares as 0/1
    endcase
endfunction

// Cycles from the first valid cycle up to and including the ready cycle
function automatic int model_cycles(ialu_cmd_e c, logic [`IALU_XLEN-1:0] a,
                                    logic [`IALU_XLEN-1:0] b);
    logic is_mul;
    is_mul = c inside {IALU_CMD_MUL, IALU_CMD_MULH, IALU_CMD_MULHSU, IALU_CMD_MULHU};
    if (is_mul && a != '0 && b != '0) begin
        return `IALU_MUL_ITERS + 1;         // IDLE cycle and one per multiplier bit
    end
    return 1;
endfunction

`endif

//--- sim/tb_ialu.sv
// Testbench of the integer ALU with random commands checked against a reference model
// Runs stand-alone and ends with a summary line and the verdict

`timescale 1ns/1ps

`include "ialu_consts.svh"

module tb_ialu
    import ialu_pkg::*;
();

    logic                  clk;
    logic                  rst_n;
    logic                  ialu_vd;
    logic [`IALU_XLEN-1:0] ialu_op1;
    logic [`IALU_XLEN-1:0] ialu_op2;
    ialu_cmd_e             ialu_cmd;
    logic [`IALU_XLEN-1:0] ialu_res;
    logic                  ialu_cmp;
    logic                  ialu_rdy;
    logic                  ialu_busy;

    int   ops;
    int   mismatches;
    int   timeouts;
    logic aborted;                              // Set on a timeout to skip later ops

    ialu_cmd_e single_cmds[8] = '{IALU_CMD_AND, IALU_CMD_OR, IALU_CMD_XOR, IALU_CMD_ADD,
                                  IALU_CMD_SUB, IALU_CMD_SLL, IALU_CMD_SRL, IALU_CMD_SRA};
    ialu_cmd_e cmp_cmds[6]    = '{IALU_CMD_LT, IALU_CMD_LTU, IALU_CMD_EQ,
                                  IALU_CMD_NE, IALU_CMD_GE, IALU_CMD_GEU};
    ialu_cmd_e mul_cmds[4]    = '{IALU_CMD_MUL, IALU_CMD_MULH, IALU_CMD_MULHSU, IALU_CMD_MULHU};

    `include "ialu_model.svh"

    ialu_top ialu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // 8 ns period
    end

    task automatic report_mismatch(string name, logic [`IALU_XLEN-1:0] exp,
                                   logic [`IALU_XLEN-1:0] act);
        mismatches++;
        $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
    endtask

    // Operand with extra weight on zero, all-ones and the minimum negative value
    function automatic logic [`IALU_XLEN-1:0] rand_operand();
        case ($urandom_range(7, 0))
            0       : return '0;
            1       : return '1;
            2       : return {1'b1, {(`IALU_XLEN-1){1'b0}}};
            default : return $urandom();
        endcase
    endfunction

    //--------------------------------------------------
    // One request held until ialu_rdy and then checked
    //--------------------------------------------------
    task automatic run_op(ialu_cmd_e c, logic [`IALU_XLEN-1:0] a, logic [`IALU_XLEN-1:0] b);
        logic [`IALU_XLEN-1:0] exp_res;
        int                    exp_cyc;
        int                    n;
        logic                  done;
        if (aborted) return;
        exp_res  = model_result(c, a, b);
        exp_cyc  = model_cycles(c, a, b);
        ialu_vd  = 1'b1;
        ialu_cmd = c;
        ialu_op1 = a;
        ialu_op2 = b;
        n        = 0;
        done     = 1'b0;
        while (!done && !aborted) begin
            @(negedge clk);                     // Mid cycle with outputs settled
            n++;
            if (ialu_rdy === 1'b1) begin
                done = 1'b1;
            end else begin
                if (ialu_busy !== 1'b1) report_mismatch("ialu_busy", 1, `IALU_XLEN'(ialu_busy));
                if (n >= 100) begin
                    $display("Timeout: ialu_rdy not seen within 100 cycles for %s", c.name());
                    timeouts++;
                    aborted = 1'b1;
                end
            end
        end
        if (!aborted) begin
            ops++;
            if (n != exp_cyc) report_mismatch("ialu_rdy cycle", exp_cyc, n);
            if (ialu_busy !== 1'b0) report_mismatch("ialu_busy", 0, `IALU_XLEN'(ialu_busy));
            if (ialu_res !== exp_res) report_mismatch("ialu_res", exp_res, ialu_res);
            if (ialu_cmp !== model_flag(c, a, b)) begin
                report_mismatch("ialu_cmp", `IALU_XLEN'(model_flag(c, a, b)),
                                `IALU_XLEN'(ialu_cmp));
            end
            @(posedge clk);                     // Completion edge
            #1;
        end
    endtask

    task automatic idle_cycle();
        ialu_vd = 1'b0;
        @(posedge clk);
        #1;
    endtask

    initial begin
        int unsigned           seed_ret;
        logic [`IALU_XLEN-1:0] a;
        logic [`IALU_XLEN-1:0] b;
        seed_ret   = $urandom(32'he09af94a);
        rst_n      = 1'b0;
        ialu_vd    = 1'b0;
        ialu_op1   = '0;
        ialu_op2   = '0;
        ialu_cmd   = IALU_CMD_AND;
        ops        = 0;
        mismatches = 0;
        timeouts   = 0;
        aborted    = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);                         // Idle after reset
        if (ialu_busy !== 1'b0) report_mismatch("ialu_busy", 0, `IALU_XLEN'(ialu_busy));
        @(posedge clk);
        #1;

        for (int i = 0; i < 200; i++) begin
            run_op(single_cmds[$urandom_range(7, 0)], rand_operand(), rand_operand());
            idle_cycle();
        end
        for (int i = 0; i < 120; i++) begin
            a = rand_operand();
            b = ((i / 6) % 3 == 0) ? a : rand_operand();   // Equal on every third pass
            run_op(cmp_cmds[i % 6], a, b);
            idle_cycle();
        end
        for (int i = 0; i < 100; i++) begin
            run_op(mul_cmds[i % 4], rand_operand(), rand_operand());
            idle_cycle();
        end
        for (int i = 0; i < 4; i++) begin
            run_op(mul_cmds[i], '0, $urandom());
            run_op(mul_cmds[i], $urandom(), '0);
        end

        //--------------------------------------------------
        // Back-to-back with valid never dropped
        //--------------------------------------------------
        for (int i = 0; i < 150; i++) begin
            run_op(ialu_cmd_e'(5'($urandom_range(17, 0))), rand_operand(), rand_operand());
        end
        ialu_vd = 1'b0;

        $display("Summary: %0d operations, %0d mismatches, %0d timeouts",
                 ops, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verilog/ialu_consts.svh
// Width and count constants shared by the ALU RTL and its testbench
// Include wherever operand, shift or multiply sizes are needed

`ifndef IALU_CONSTS_SVH
`define IALU_CONSTS_SVH

//--------------------------------------------------
// Datapath widths
//--------------------------------------------------

// Operand and result width
`define IALU_XLEN           32

// Shift amount taken from the low bits of operand 2
`define IALU_SHAMT_W        5

//--------------------------------------------------
// Serial multiplier
//--------------------------------------------------

// Iteration counter width that holds IALU_MUL_ITERS-1
`define IALU_CNT_W          5

// One multiplier bit per iteration
`define IALU_MUL_ITERS      32

`endif

//--- verilog/ialu_decode.sv
// Command decoder of the integer ALU
// Splits a command into the class and sub-fields used by the datapath

`timescale 1ns/1ps

module ialu_decode
    import ialu_pkg::*;
(
    input  ialu_cmd_e ialu_cmd,
    output ialu_op_s  op
);

    always_comb begin
        op            = '0;
        op.cls        = IALU_CLS_LOGIC;
        op.log_kind   = IALU_LOG_AND;
        op.cmp_kind   = IALU_CMP_LT;
        op.shf_kind   = IALU_SHF_SLL;

        case (ialu_cmd)
            //--------------------------------------------------
            // Logic and arithmetic
            //--------------------------------------------------
            IALU_CMD_AND : op.log_kind = IALU_LOG_AND;
            IALU_CMD_OR  : op.log_kind = IALU_LOG_OR;
            IALU_CMD_XOR : op.log_kind = IALU_LOG_XOR;
            IALU_CMD_ADD : op.cls      = IALU_CLS_ARITH;
            IALU_CMD_SUB : begin
                op.cls = IALU_CLS_ARITH;
                op.sub = 1'b1;
            end
            //--------------------------------------------------
            // Compares all taken from one subtraction
            //--------------------------------------------------
            IALU_CMD_LT, IALU_CMD_LTU, IALU_CMD_EQ,
            IALU_CMD_NE, IALU_CMD_GE, IALU_CMD_GEU : begin
                op.cls = IALU_CLS_CMP;
                op.sub = 1'b1;
                case (ialu_cmd)
                    IALU_CMD_LT  : op.cmp_kind = IALU_CMP_LT;
                    IALU_CMD_LTU : op.cmp_kind = IALU_CMP_LTU;
                    IALU_CMD_EQ  : op.cmp_kind = IALU_CMP_EQ;
                    IALU_CMD_NE  : op.cmp_kind = IALU_CMP_NE;
                    IALU_CMD_GE  : op.cmp_kind = IALU_CMP_GE;
                    default      : op.cmp_kind = IALU_CMP_GEU;
                endcase
            end
            //--------------------------------------------------
            // Shifts
            //--------------------------------------------------
            IALU_CMD_SLL : begin
                op.cls      = IALU_CLS_SHIFT;
                op.shf_kind = IALU_SHF_SLL;
            end
            IALU_CMD_SRL : begin
                op.cls      = IALU_CLS_SHIFT;
                op.shf_kind = IALU_SHF_SRL;
            end
            IALU_CMD_SRA : begin
                op.cls      = IALU_CLS_SHIFT;
                op.shf_kind = IALU_SHF_SRA;
            end
            //--------------------------------------------------
            // Multiplies
            //--------------------------------------------------
            IALU_CMD_MUL, IALU_CMD_MULH, IALU_CMD_MULHSU, IALU_CMD_MULHU : begin
                op.cls        = IALU_CLS_MUL;
                op.mul_high   = (ialu_cmd != IALU_CMD_MUL);
                op.op1_signed = (ialu_cmd != IALU_CMD_MULHU);       // MULHSU keeps op1 signed
                op.op2_signed = (ialu_cmd == IALU_CMD_MUL) | (ialu_cmd == IALU_CMD_MULH);
            end
            default : begin end
        endcase
    end

endmodule

//--- verilog/ialu_pkg.sv
// Types of the integer ALU for commands, compare flags and decoded operations
// Imported by every ALU module and by the testbench

package ialu_pkg;

    // ALU command as issued by the execution stage
    typedef enum logic [4:0] {
        IALU_CMD_AND,
        IALU_CMD_OR,
        IALU_CMD_XOR,
        IALU_CMD_ADD,
        IALU_CMD_SUB,
        IALU_CMD_LT,
        IALU_CMD_LTU,
        IALU_CMD_EQ,
        IALU_CMD_NE,
        IALU_CMD_GE,
        IALU_CMD_GEU,
        IALU_CMD_SLL,
        IALU_CMD_SRL,
        IALU_CMD_SRA,
        IALU_CMD_MUL,
        IALU_CMD_MULH,
        IALU_CMD_MULHSU,
        IALU_CMD_MULHU
    } ialu_cmd_e;

    // Flags of the subtraction op1 - op2
    typedef struct packed {
        logic z;                                // Zero
        logic s;                                // Sign
        logic o;                                // Signed overflow
        logic c;                                // Borrow out
    } ialu_flags_s;

    typedef enum logic [2:0] {
        IALU_CLS_LOGIC,
        IALU_CLS_ARITH,
        IALU_CLS_CMP,
        IALU_CLS_SHIFT,
        IALU_CLS_MUL
    } ialu_class_e;

    typedef enum logic [1:0] {IALU_LOG_AND, IALU_LOG_OR, IALU_LOG_XOR} ialu_log_e;

    typedef enum logic [2:0] {
        IALU_CMP_LT, IALU_CMP_LTU, IALU_CMP_EQ, IALU_CMP_NE, IALU_CMP_GE, IALU_CMP_GEU
    } ialu_cmp_e;

    typedef enum logic [1:0] {IALU_SHF_SLL, IALU_SHF_SRL, IALU_SHF_SRA} ialu_shf_e;

    // Decoded operation of 14 bits
    typedef struct packed {
        ialu_class_e cls;                       // Result path select
        logic        sub;                       // Adder subtracts
        ialu_log_e   log_kind;
        ialu_cmp_e   cmp_kind;
        ialu_shf_e   shf_kind;
        logic        mul_high;                  // Upper product word wanted
        logic        op1_signed;
        logic        op2_signed;
    } ialu_op_s;

endpackage

//--- verilog/ialu_result_unit.sv
// Single-cycle datapath of the integer ALU
// Adder with compare flags, logic ops, shifter and the final result mux;
// the multiply word arrives ready from the serial multiplier

`timescale 1ns/1ps

`include "ialu_consts.svh"

module ialu_result_unit
    import ialu_pkg::*;
(
    input  logic [`IALU_XLEN-1:0] ialu_op1,
    input  logic [`IALU_XLEN-1:0] ialu_op2,
    input  ialu_op_s              op,
    input  logic [`IALU_XLEN-1:0] mul_res,
    output logic [`IALU_XLEN-1:0] ialu_res,
    output logic                  ialu_cmp
);

    logic [`IALU_XLEN:0]     sum_res;           // Extra bit is the borrow
    ialu_flags_s             flags;
    logic                    cmp_flag;
    logic [`IALU_XLEN-1:0]   log_res;
    logic [`IALU_SHAMT_W-1:0] shamt;
    logic [`IALU_XLEN-1:0]   shft_res;

    //--------------------------------------------------
    // Adder / subtractor and flags
    //--------------------------------------------------
    always_comb begin
        if (op.sub) begin
            sum_res = {1'b0, ialu_op1} - {1'b0, ialu_op2};
        end else begin
            sum_res = {1'b0, ialu_op1} + {1'b0, ialu_op2};
        end

        flags.c = sum_res[`IALU_XLEN];
        flags.z = ~|sum_res[`IALU_XLEN-1:0];
        flags.s = sum_res[`IALU_XLEN-1];
        // Operands of unlike sign whose difference took the sign of op2
        flags.o = (ialu_op1[`IALU_XLEN-1] ^ ialu_op2[`IALU_XLEN-1]) &
                  (sum_res[`IALU_XLEN-1] ^ ialu_op1[`IALU_XLEN-1]);
    end

    always_comb begin
        case (op.cmp_kind)
            IALU_CMP_LT  : cmp_flag = flags.s ^ flags.o;
            IALU_CMP_LTU : cmp_flag = flags.c;
            IALU_CMP_EQ  : cmp_flag = flags.z;
            IALU_CMP_NE  : cmp_flag = ~flags.z;
            IALU_CMP_GE  : cmp_flag = ~(flags.s ^ flags.o);
            default      : cmp_flag = ~flags.c;     // GEU
        endcase
    end

    //--------------------------------------------------
    // Logic ops and shifter
    //--------------------------------------------------
    always_comb begin
        case (op.log_kind)
            IALU_LOG_OR  : log_res = ialu_op1 | ialu_op2;
            IALU_LOG_XOR : log_res = ialu_op1 ^ ialu_op2;
            default      : log_res = ialu_op1 & ialu_op2;
        endcase
    end

    assign shamt = ialu_op2[`IALU_SHAMT_W-1:0];

    always_comb begin
        case (op.shf_kind)
            IALU_SHF_SRL : shft_res = ialu_op1 >> shamt;
            IALU_SHF_SRA : shft_res = $signed(ialu_op1) >>> shamt;
            default      : shft_res = ialu_op1 << shamt;
        endcase
    end

    //--------------------------------------------------
    // Result select
    //--------------------------------------------------
    always_comb begin
        ialu_cmp = 1'b0;
        case (op.cls)
            IALU_CLS_ARITH : ialu_res = sum_res[`IALU_XLEN-1:0];
            IALU_CLS_CMP   : begin
                ialu_res = `IALU_XLEN'(cmp_flag);  // Flag as 0/1 word
                ialu_cmp = cmp_flag;
            end
            IALU_CLS_SHIFT : ialu_res = shft_res;
            IALU_CLS_MUL   : ialu_res = mul_res;
            default        : ialu_res = log_res;
        endcase
    end

endmodule

//--- verilog/ialu_serial_mul.sv
// Shift-add multiplier of the integer ALU that takes one multiplier bit per cycle
// Owns ialu_rdy as well. Single-cycle commands are always ready and a multiply
// of two non-zero operands spends one IDLE cycle and IALU_MUL_ITERS ITER cycles

`timescale 1ns/1ps

`include "ialu_consts.svh"

module ialu_serial_mul
    import ialu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ialu_vd,
    input  logic [`IALU_XLEN-1:0] ialu_op1,
    input  logic [`IALU_XLEN-1:0] ialu_op2,
    input  ialu_op_s              op,
    output logic [`IALU_XLEN-1:0] mul_res,
    output logic                  ialu_rdy
);

    localparam logic [`IALU_CNT_W-1:0] MUL_INIT_CNT = `IALU_CNT_W'(`IALU_MUL_ITERS - 1);

    typedef enum logic {
        MUL_IDLE,
        MUL_ITER
    } mul_state_e;

    mul_state_e               state;
    mul_state_e               state_nxt;
    logic [`IALU_CNT_W-1:0]   cnt_q;            // Iterations left after this one
    logic [`IALU_XLEN-1:0]    hi_q;             // Partial product, upper word
    logic [`IALU_XLEN-1:0]    lo_q;             // Product low bits above and multiplier bits below

    logic                     is_mul;
    logic                     zero_op;
    logic                     mul_start;
    logic                     last_step;
    logic                     mul_done;
    logic                     step_sub;
    logic [`IALU_XLEN:0]      mcand;
    logic [`IALU_XLEN:0]      hi_ext;
    logic [`IALU_XLEN:0]      acc;
    logic [`IALU_XLEN-1:0]    hi_nxt;
    logic [`IALU_XLEN-1:0]    lo_nxt;

    assign is_mul    = (op.cls == IALU_CLS_MUL);
    assign zero_op   = ~|ialu_op1 | ~|ialu_op2;     // Product is known at once
    assign mul_start = (state == MUL_IDLE) & ialu_vd & is_mul & ~zero_op;
    assign last_step = (cnt_q == '0);
    assign mul_done  = is_mul & (state == MUL_ITER) & last_step;

    //--------------------------------------------------
    // Control FSM and iteration counter
    //--------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            MUL_IDLE : if (is_mul & ~zero_op) state_nxt = MUL_ITER;
            MUL_ITER : if (last_step) state_nxt = MUL_IDLE;
            default  : state_nxt = MUL_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= MUL_IDLE;
            cnt_q <= '0;
        end else begin
            if (!ialu_vd) begin
                state <= MUL_IDLE;                  // Requester withdrew the command
            end else begin
                state <= state_nxt;
            end
            if (state == MUL_IDLE) begin
                cnt_q <= MUL_INIT_CNT;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    //--------------------------------------------------
    // Shift-add step
    //--------------------------------------------------
    always_comb begin
        mcand  = {op.op1_signed & ialu_op1[`IALU_XLEN-1], ialu_op1};
        hi_ext = {op.op1_signed & hi_q[`IALU_XLEN-1], hi_q};
        // Top bit of a signed multiplier weighs -2^(XLEN-1)
        step_sub = last_step & op.op2_signed;

        if (!lo_q[0]) begin
            acc = hi_ext;
        end else if (step_sub) begin
            acc = hi_ext - mcand;
        end else begin
            acc = hi_ext + mcand;
        end

        hi_nxt = acc[`IALU_XLEN:1];
        lo_nxt = {acc[0], lo_q[`IALU_XLEN-1:1]};
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            hi_q <= '0;
            lo_q <= ialu_op2;                       // Multiplier consumed from bit 0
        end else if (state == MUL_ITER) begin
            hi_q <= hi_nxt;
            lo_q <= lo_nxt;
        end
    end

    //--------------------------------------------------
    // Outputs
    //--------------------------------------------------
    always_comb begin
        mul_res = '0;                               // Also the zero-operand product
        if (mul_done) begin
            mul_res = op.mul_high ? hi_nxt : lo_nxt;
        end
    end

    assign ialu_rdy = ~is_mul | zero_op | mul_done;

    //--------------------------------------------------
    // Assertions
    //--------------------------------------------------
    a_no_unknown : assert property (
        @(posedge clk) disable iff (!rst_n)
        !ialu_vd |-> !$isunknown(state)
    ) else $error("ialu_serial_mul: unknown state");

    a_vd_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(ialu_vd)
    ) else $error("ialu_serial_mul: unknown valid");

    // A multiply issued after a dropped valid starts over from IDLE
    a_drop_to_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        !ialu_vd ##1 (ialu_vd & is_mul & !zero_op) |-> !ialu_rdy
    ) else $error("ialu_serial_mul: multiply ready at once after valid dropped");

    a_iter_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        ((state == MUL_ITER) & ialu_vd & !ialu_rdy) |=> (state == MUL_ITER)
    ) else $error("ialu_serial_mul: left ITER before completion");

endmodule

//--- verilog/ialu_top.sv
// Integer ALU of the execution stage
// Request with ialu_vd held and operands stable; the result is taken at the
// rising edge where ialu_vd and ialu_rdy are both high

`timescale 1ns/1ps

`include "ialu_consts.svh"

module ialu_top
    import ialu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  ialu_vd,
    input  logic [`IALU_XLEN-1:0] ialu_op1,
    input  logic [`IALU_XLEN-1:0] ialu_op2,
    input  ialu_cmd_e             ialu_cmd,

    output logic [`IALU_XLEN-1:0] ialu_res,
    output logic                  ialu_cmp,
    output logic                  ialu_rdy,
    output logic                  ialu_busy
);

    ialu_op_s               op;
    logic [`IALU_XLEN-1:0]  mul_res;

    //--------------------------------------------------
    // Decode, datapath, multiplier
    //--------------------------------------------------
    ialu_decode ialu_decode_i (
        .ialu_cmd (ialu_cmd),
        .op       (op)
    );

    ialu_result_unit ialu_result_unit_i (
        .ialu_op1 (ialu_op1),
        .ialu_op2 (ialu_op2),
        .op       (op),
        .mul_res  (mul_res),
        .ialu_res (ialu_res),
        .ialu_cmp (ialu_cmp)
    );

    ialu_serial_mul ialu_serial_mul_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ialu_vd  (ialu_vd),
        .ialu_op1 (ialu_op1),
        .ialu_op2 (ialu_op2),
        .op       (op),
        .mul_res  (mul_res),
        .ialu_rdy (ialu_rdy)
    );

    assign ialu_busy = ialu_vd & ~ialu_rdy;        // Stalls the pipeline

endmodule
